/* core_pkg.sv */
`default_nettype none

package core_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [31:0]           inst_t;

    localparam xlen_t RESET_PC = 32'h0000_0000;

    // Major opcodes of the supported subset
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {OP1_RS1, OP1_PC, OP1_ZERO} op1_sel_e;
    typedef enum logic       {OP2_RS2, OP2_IMM} op2_sel_e;
    typedef enum logic [1:0] {PC_PLUS4, PC_BRANCH, PC_JAL, PC_JALR} pc_sel_e;
    typedef enum logic       {WB_ALU, WB_PC4} wb_sel_e;

    typedef struct packed {
        alu_op_e  alu_op;
        op1_sel_e op1_sel;
        op2_sel_e op2_sel;
        pc_sel_e  pc_sel;
        wb_sel_e  wb_sel;
        logic     rf_we;
    } ctrl_t;

    typedef struct packed {
        logic eq;
        logic lt;
        logic ltu;
    } br_flags_t;

    // One retired register write
    typedef struct packed {
        logic      we;
        xlen_t     pc;
        reg_addr_t rd;
        xlen_t     data;
    } commit_t;

endpackage

`default_nettype wire

/* core_ifu.sv */
`timescale 1ns/1ps
`default_nettype none

module core_ifu
    import core_pkg::*;
(
    input  wire            clk,
    input  wire            arst_n_i,
    input  wire pc_sel_e   pc_sel_i,
    input  wire xlen_t     br_target_i,
    input  wire xlen_t     jal_target_i,
    input  wire xlen_t     jalr_target_i,
    input  wire inst_t     imem_rdata_i,
    output xlen_t          pc_o,
    output inst_t          inst_o
);

    xlen_t pc_q;
    xlen_t pc_plus4;
    xlen_t pc_next;

    assign pc_plus4 = pc_q + 32'd4;

    // Branch decision is already folded into the select
    always_comb begin
        case (pc_sel_i)
            PC_BRANCH: pc_next = br_target_i;
            PC_JAL:    pc_next = jal_target_i;
            PC_JALR:   pc_next = jalr_target_i;
            default:   pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= RESET_PC;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign pc_o   = pc_q;
    // Instruction memory answers in the same cycle
    assign inst_o = imem_rdata_i;

endmodule

`default_nettype wire

/* core_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module core_regfile
    import core_pkg::*;
(
    input  wire            clk,
    input  wire            we_i,
    input  wire reg_addr_t waddr_i,
    input  wire reg_addr_t raddr1_i,
    input  wire reg_addr_t raddr2_i,
    input  wire xlen_t     wdata_i,
    output xlen_t          rdata1_o,
    output xlen_t          rdata2_o
);

    // x1..x31 only, x0 has no storage
    xlen_t regs_q [1:2**REG_ADDR_W-1];

    always_ff @(posedge clk) begin
        if (we_i) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

    always_comb begin
        if (raddr1_i == '0) begin
            rdata1_o = '0;
        end else begin
            rdata1_o = regs_q[raddr1_i];
        end
    end

    always_comb begin
        if (raddr2_i == '0) begin
            rdata2_o = '0;
        end else begin
            rdata2_o = regs_q[raddr2_i];
        end
    end

endmodule

`default_nettype wire

/* core_idu.sv */
`timescale 1ns/1ps
`default_nettype none

module core_idu
    import core_pkg::*;
(
    input  wire inst_t     inst_i,
    input  wire xlen_t     pc_i,
    input  wire xlen_t     rs1_data_i,
    input  wire xlen_t     rs2_data_i,
    input  wire op1_sel_e  op1_sel_i,
    input  wire op2_sel_e  op2_sel_i,
    output reg_addr_t      rs1_addr_o,
    output reg_addr_t      rs2_addr_o,
    output reg_addr_t      rd_addr_o,
    output xlen_t          op_a_o,
    output xlen_t          op_b_o,
    output xlen_t          br_target_o,
    output xlen_t          jal_target_o,
    output xlen_t          jalr_target_o,
    output br_flags_t      br_flags_o
);

    xlen_t imm_i;
    xlen_t imm_u;
    xlen_t imm_b;
    xlen_t imm_j;
    xlen_t imm_op;
    xlen_t jalr_sum;
    logic  is_upper;

    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];
    assign rd_addr_o  = inst_i[11:7];

    // Immediate formats, all sign extended from bit 31
    assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign imm_b = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                    inst_i[11:8], 1'b0};
    assign imm_j = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20],
                    inst_i[30:21], 1'b0};

    // LUI and AUIPC take the U form, everything else on op_b uses I
    assign is_upper = (inst_i[6:0] == OPC_LUI) || (inst_i[6:0] == OPC_AUIPC);
    assign imm_op   = is_upper ? imm_u : imm_i;

    always_comb begin
        case (op1_sel_i)
            OP1_PC:   op_a_o = pc_i;
            OP1_ZERO: op_a_o = '0;
            default:  op_a_o = rs1_data_i;
        endcase
    end

    always_comb begin
        case (op2_sel_i)
            OP2_IMM: op_b_o = imm_op;
            default: op_b_o = rs2_data_i;
        endcase
    end

    // Jump and branch targets
    assign br_target_o   = pc_i + imm_b;
    assign jal_target_o  = pc_i + imm_j;
    assign jalr_sum      = rs1_data_i + imm_i;
    assign jalr_target_o = {jalr_sum[XLEN-1:1], 1'b0};

    // Compare flags for the branch decision in control
    assign br_flags_o.eq  = (rs1_data_i == rs2_data_i);
    assign br_flags_o.lt  = ($signed(rs1_data_i) < $signed(rs2_data_i));
    assign br_flags_o.ltu = (rs1_data_i < rs2_data_i);

endmodule

`default_nettype wire

/* core_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module core_ctrl
    import core_pkg::*;
(
    input  wire inst_t     inst_i,
    input  wire br_flags_t br_flags_i,
    output ctrl_t          ctrl_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_zero;
    logic       br_taken;
    ctrl_t      dec;

    assign opcode  = inst_i[6:0];
    assign funct3  = inst_i[14:12];
    assign funct7  = inst_i[31:25];
    assign rd_zero = (inst_i[11:7] == '0);

    // Branch condition by funct3, reserved codes never take
    always_comb begin
        case (funct3)
            3'b000:  br_taken = br_flags_i.eq;
            3'b001:  br_taken = !br_flags_i.eq;
            3'b100:  br_taken = br_flags_i.lt;
            3'b101:  br_taken = !br_flags_i.lt;
            3'b110:  br_taken = br_flags_i.ltu;
            3'b111:  br_taken = !br_flags_i.ltu;
            default: br_taken = 1'b0;
        endcase
    end

    always_comb begin
        // Unknown encodings fall through as a no-op
        dec = '{alu_op: ALU_ADD, op1_sel: OP1_RS1, op2_sel: OP2_RS2,
                pc_sel: PC_PLUS4, wb_sel: WB_ALU, rf_we: 1'b0};
        case (opcode)
            OPC_OP: begin
                dec.rf_we = 1'b1;
                case ({funct7, funct3})
                    10'b0000000_000: dec.alu_op = ALU_ADD;
                    10'b0100000_000: dec.alu_op = ALU_SUB;
                    10'b0000000_001: dec.alu_op = ALU_SLL;
                    10'b0000000_010: dec.alu_op = ALU_SLT;
                    10'b0000000_011: dec.alu_op = ALU_SLTU;
                    10'b0000000_100: dec.alu_op = ALU_XOR;
                    10'b0000000_101: dec.alu_op = ALU_SRL;
                    10'b0100000_101: dec.alu_op = ALU_SRA;
                    10'b0000000_110: dec.alu_op = ALU_OR;
                    10'b0000000_111: dec.alu_op = ALU_AND;
                    default:         dec.rf_we  = 1'b0;
                endcase
            end
            OPC_OP_IMM: begin
                dec.op2_sel = OP2_IMM;
                dec.rf_we   = 1'b1;
                case (funct3)
                    3'b000:  dec.alu_op = ALU_ADD;
                    3'b010:  dec.alu_op = ALU_SLT;
                    3'b011:  dec.alu_op = ALU_SLTU;
                    3'b100:  dec.alu_op = ALU_XOR;
                    3'b110:  dec.alu_op = ALU_OR;
                    3'b111:  dec.alu_op = ALU_AND;
                    // immediate shifts are outside the subset
                    default: dec.rf_we  = 1'b0;
                endcase
            end
            OPC_LUI: begin
                dec.alu_op  = ALU_PASS_B;
                dec.op1_sel = OP1_ZERO;
                dec.op2_sel = OP2_IMM;
                dec.rf_we   = 1'b1;
            end
            OPC_AUIPC: begin
                dec.op1_sel = OP1_PC;
                dec.op2_sel = OP2_IMM;
                dec.rf_we   = 1'b1;
            end
            OPC_JAL: begin
                dec.pc_sel = PC_JAL;
                dec.wb_sel = WB_PC4;
                dec.rf_we  = 1'b1;
            end
            OPC_JALR: begin
                if (funct3 == 3'b000) begin
                    dec.pc_sel = PC_JALR;
                    dec.wb_sel = WB_PC4;
                    dec.rf_we  = 1'b1;
                end
            end
            OPC_BRANCH: begin
                dec.pc_sel = br_taken ? PC_BRANCH : PC_PLUS4;
            end
            default: ;
        endcase
        // Writes to x0 are dropped here and nowhere else
        if (rd_zero) begin
            dec.rf_we = 1'b0;
        end
    end

    assign ctrl_o = dec;

endmodule

`default_nettype wire

/* core_exu.sv */
`timescale 1ns/1ps
`default_nettype none

module core_exu
    import core_pkg::*;
(
    input  wire xlen_t    op_a_i,
    input  wire xlen_t    op_b_i,
    input  wire xlen_t    pc_i,
    input  wire alu_op_e  alu_op_i,
    input  wire wb_sel_e  wb_sel_i,
    output xlen_t         wb_data_o
);

    xlen_t      alu_res;
    xlen_t      pc_plus4;
    logic [4:0] shamt;

    // Only the low five bits count for shifts
    assign shamt = op_b_i[4:0];

    always_comb begin
        case (alu_op_i)
            ALU_ADD:    alu_res = op_a_i + op_b_i;
            ALU_SUB:    alu_res = op_a_i - op_b_i;
            ALU_AND:    alu_res = op_a_i & op_b_i;
            ALU_OR:     alu_res = op_a_i | op_b_i;
            ALU_XOR:    alu_res = op_a_i ^ op_b_i;
            ALU_SLT:    alu_res = {31'b0, $signed(op_a_i) < $signed(op_b_i)};
            ALU_SLTU:   alu_res = {31'b0, op_a_i < op_b_i};
            ALU_SLL:    alu_res = op_a_i << shamt;
            ALU_SRL:    alu_res = op_a_i >> shamt;
            ALU_SRA:    alu_res = xlen_t'($signed(op_a_i) >>> shamt);
            ALU_PASS_B: alu_res = op_b_i;
            default:    alu_res = '0;
        endcase
    end

    // Link value for JAL and JALR
    assign pc_plus4 = pc_i + 32'd4;

    always_comb begin
        case (wb_sel_i)
            WB_PC4:  wb_data_o = pc_plus4;
            default: wb_data_o = alu_res;
        endcase
    end

endmodule

`default_nettype wire

/* core_top.sv */
`timescale 1ns/1ps
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  wire        clk,
    input  wire        arst_n_i,
    // Instruction port, read combinationally
    output xlen_t      imem_addr_o,
    input  wire inst_t imem_rdata_i,
    output commit_t    commit_o
);

    xlen_t     pc;
    inst_t     inst;
    ctrl_t     ctrl;
    br_flags_t br_flags;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     op_a;
    xlen_t     op_b;
    xlen_t     br_target;
    xlen_t     jal_target;
    xlen_t     jalr_target;
    xlen_t     wb_data;
    logic      wb_en;

    core_ifu u_ifu (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .pc_sel_i      (ctrl.pc_sel),
        .br_target_i   (br_target),
        .jal_target_i  (jal_target),
        .jalr_target_i (jalr_target),
        .imem_rdata_i  (imem_rdata_i),
        .pc_o          (pc),
        .inst_o        (inst)
    );

    assign imem_addr_o = pc;

    core_idu u_idu (
        .inst_i        (inst),
        .pc_i          (pc),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .op1_sel_i     (ctrl.op1_sel),
        .op2_sel_i     (ctrl.op2_sel),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .rd_addr_o     (rd_addr),
        .op_a_o        (op_a),
        .op_b_o        (op_b),
        .br_target_o   (br_target),
        .jal_target_o  (jal_target),
        .jalr_target_o (jalr_target),
        .br_flags_o    (br_flags)
    );

    core_ctrl u_ctrl (
        .inst_i     (inst),
        .br_flags_i (br_flags),
        .ctrl_o     (ctrl)
    );

    core_exu u_exu (
        .op_a_i    (op_a),
        .op_b_i    (op_b),
        .pc_i      (pc),
        .alu_op_i  (ctrl.alu_op),
        .wb_sel_i  (ctrl.wb_sel),
        .wb_data_o (wb_data)
    );

    // Nothing retires while the core is held in reset
    assign wb_en = ctrl.rf_we & arst_n_i;

    core_regfile u_regfile (
        .clk      (clk),
        .we_i     (wb_en),
        .waddr_i  (rd_addr),
        .raddr1_i (rs1_addr),
        .raddr2_i (rs2_addr),
        .wdata_i  (wb_data),
        .rdata1_o (rs1_data),
        .rdata2_o (rs2_data)
    );

    assign commit_o.we   = wb_en;
    assign commit_o.pc   = pc;
    assign commit_o.rd   = rd_addr;
    assign commit_o.data = wb_data;

endmodule

`default_nettype wire

/* core_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module core_assert
    import core_pkg::*;
(
    input wire          clk,
    input wire          arst_n_i,
    input wire xlen_t   imem_addr_i,
    input wire commit_t commit_i
);

    // Number of failed assertions
    int fail_cnt = 0;

    // Fetch address stays on a word boundary
    a_fetch_aligned: assert property (@(posedge clk) disable iff (!arst_n_i)
        imem_addr_i[1:0] == 2'b00)
        else begin
            $error("instruction fetch address %h is not word aligned", imem_addr_i);
            fail_cnt++;
        end

    // x0 is never reported as a write target
    a_no_x0_commit: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_i.we |-> (commit_i.rd != '0))
        else begin
            $error("commit reports a write to x0 from pc %h", commit_i.pc);
            fail_cnt++;
        end

    // Quiet commit port while held in reset
    a_reset_quiet: assert property (@(posedge clk) !arst_n_i |-> !commit_i.we)
        else begin
            $error("commit write enable raised during reset");
            fail_cnt++;
        end

endmodule

bind core_top core_assert u_core_assert (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .imem_addr_i (imem_addr_o),
    .commit_i    (commit_o)
);

`default_nettype wire

/* tb_core.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_core
    import core_pkg::*;
();

    localparam int PROG_WORDS  = 64;
    localparam int MAX_RECS    = 64;
    localparam int REC_BASE    = 64;
    localparam int WAIT_CYCLES = 2000;
    localparam int DRAIN       = 8;

    logic        clk;
    logic        arst_n;
    xlen_t       imem_addr;
    inst_t       imem_rdata;
    commit_t     commit;

    logic [31:0] file_mem [0:255];
    inst_t       prog_mem [0:PROG_WORDS-1];
    commit_t     exp_rec  [0:MAX_RECS-1];
    int          n_rec;
    int          rec_idx;
    int          err_cnt;
    int          timeout_cnt;

    core_top UUT (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .imem_addr_o  (imem_addr),
        .imem_rdata_i (imem_rdata),
        .commit_o     (commit)
    );

    // Instruction memory answers in the same cycle
    assign imem_rdata = prog_mem[imem_addr[7:2]];

    always #10 clk = ~clk;

    // Program at word 0, record count at REC_BASE, then pc/rd/value triples
    task automatic load_tests();
        int i;
        $readmemh("core_tests.txt", file_mem);
        for (i = 0; i < PROG_WORDS; i++) begin
            prog_mem[i] = file_mem[i];
        end
        if ($isunknown(file_mem[REC_BASE]) || file_mem[REC_BASE] == 0 ||
            file_mem[REC_BASE] > MAX_RECS) begin
            err_cnt++;
            $display("core_tests.txt holds no valid record count");
            n_rec = 0;
        end else begin
            n_rec = file_mem[REC_BASE];
        end
        for (i = 0; i < n_rec; i++) begin
            exp_rec[i].pc   = file_mem[REC_BASE + 1 + 3 * i];
            exp_rec[i].rd   = reg_addr_t'(file_mem[REC_BASE + 2 + 3 * i]);
            exp_rec[i].data = file_mem[REC_BASE + 3 + 3 * i];
        end
    endtask

    task automatic wait_for_records();
        int cycles;
        cycles = 0;
        while (rec_idx < n_rec && cycles < WAIT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (rec_idx < n_rec) begin
            timeout_cnt++;
            $display("Timeout after %0d cycles, only %0d of %0d commits seen",
                     cycles, rec_idx, n_rec);
        end
    endtask

    // Commit port is stable mid-cycle
    always @(negedge clk) begin
        if (arst_n && commit.we) begin
            if (rec_idx >= n_rec) begin
                err_cnt++;
                $display("Unexpected commit at %0t from pc %h writing x%0d",
                         $time, commit.pc, commit.rd);
            end else begin
                if (commit.pc !== exp_rec[rec_idx].pc) begin
                    err_cnt++;
                    $display("ERROR at %0t: commit_o.pc expected %h, got %h",
                             $time, exp_rec[rec_idx].pc, commit.pc);
                end
                if (commit.rd !== exp_rec[rec_idx].rd) begin
                    err_cnt++;
                    $display("ERROR at %0t: commit_o.rd expected %0d, got %0d",
                             $time, exp_rec[rec_idx].rd, commit.rd);
                end
                if (commit.data !== exp_rec[rec_idx].data) begin
                    err_cnt++;
                    $display("ERROR at %0t: commit_o.data expected %h, got %h",
                             $time, exp_rec[rec_idx].data, commit.data);
                end
            end
            rec_idx++;
        end
    end

    initial begin
        clk         = 1'b0;
        arst_n      = 1'b0;
        rec_idx     = 0;
        err_cnt     = 0;
        timeout_cnt = 0;
        load_tests();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        wait_for_records();
        // A few idle cycles to catch stray commits after the last record
        repeat (DRAIN) @(negedge clk);
        $display("Commits checked %0d of %0d, errors %0d, timeouts %0d, assertion failures %0d",
                 rec_idx, n_rec, err_cnt, timeout_cnt, UUT.u_core_assert.fail_cnt);
        if (err_cnt == 0 && timeout_cnt == 0 && UUT.u_core_assert.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb.f */
core_pkg.sv
core_ifu.sv
core_regfile.sv
core_idu.sv
core_ctrl.sv
core_exu.sv
core_top.sv
core_assert.sv
tb_core.sv

/* core_tests.txt */
// Program words from pc 0 upward, the comment gives the pc of the first word
// At @40 the record count, then one record per line: pc rd value
@00
00500093 ffd00113 002081b3 40208233 // 00 addi x1 5, addi x2 -3, add, sub
0020f2b3 0020e333 0020c3b3 00112433 // 10 and, or, xor, slt
001134b3 00109533 001155b3 40115633 // 20 sltu, sll, srl, sra
ffe12693 fff0b713 fff0c793 0700e813 // 30 slti, sltiu, xori, ori
7f017893 12345937 00001997 00708013 // 40 andi, lui, auipc, addi to x0
00100a33 02100a93 01509b33          // 50 add from x0, addi 33, sll by 33
00208463 00100b93 00108463 fff00c13 00200b93 // 5c beq not taken, taken
00109463 00300b93 00209463 fff00c13 00400b93 // 70 bne
0020c463 00500b93 00114463 fff00c13 00600b93 // 84 blt
00115463 00700b93 0020d463 fff00c13 00800b93 // 98 bge
00116463 00900b93 0020e463 fff00c13 00a00b93 // ac bltu
0020f463 00b00b93 00117463 fff00c13 00c00b93 // c0 bgeu
00800cef fff00c13 00000d17 00dd0de7          // d4 jal, skipped, auipc, jalr
fff00c13 00d00b93 0000006f                   // e4 skipped, marker, jump to self
@40
00000026
00000000 01 00000005
00000004 02 fffffffd
00000008 03 00000002
0000000c 04 00000008
00000010 05 00000005
00000014 06 fffffffd
00000018 07 fffffff8
0000001c 08 00000001
00000020 09 00000000
00000024 0a 000000a0
00000028 0b 07ffffff
0000002c 0c ffffffff
00000030 0d 00000001
00000034 0e 00000001
00000038 0f fffffffa
0000003c 10 00000075
00000040 11 000007f0
00000044 12 12345000
00000048 13 00001048
00000050 14 00000005
00000054 15 00000021
00000058 16 0000000a
00000060 17 00000001
0000006c 17 00000002
00000074 17 00000003
00000080 17 00000004
00000088 17 00000005
00000094 17 00000006
0000009c 17 00000007
000000a8 17 00000008
000000b0 17 00000009
000000bc 17 0000000a
000000c4 17 0000000b
000000d0 17 0000000c
000000d4 19 000000d8
000000dc 1a 000000dc
000000e0 1b 000000e4
000000e8 17 0000000d
